//--- all.f
hdl/hmac_rng_param_pkg.sv
hdl/hmac_rng_ctrl_pkg.sv
hdl/hmac_lfsr.sv
hdl/hmac_mask_combiner.sv
hdl/hmac_mask_gen.sv
tests/tb_clock_gen.sv
tests/tb_hmac_mask_gen.sv

//--- Makefile
# Verilator build and run of the HMAC mask generator testbench
# Any variable below can be overridden, e.g. make test LOG=run.log

VERILATOR ?= verilator
TOP       ?= tb_hmac_mask_gen
FILELIST  ?= all.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0
PASS_MSG  ?= test passed

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run, check $(LOG) for the pass line"
	@echo "  clean  remove $(BUILD_DIR) and $(LOG)"
	@echo "  help   show this list"
	@echo "Variables: VERILATOR TOP FILELIST BUILD_DIR LOG VFLAGS"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)
	-./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -qx "$(PASS_MSG)" $(LOG); then \
	  echo "Simulation PASSED"; \
	else \
	  echo "Simulation FAILED, see $(LOG)"; \
	  exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)

//--- tests/tb_hmac_mask_gen.sv
`timescale 1ns/1ns

module tb_hmac_mask_gen;

  import hmac_rng_param_pkg::*;
  import hmac_rng_ctrl_pkg::*;

  // ----------------------------------------
  // Run length
  // ----------------------------------------

  localparam int CLK_PERIOD   = 20;
  localparam int RESET_CYCLES = 5;
  localparam int REP_LIMIT    = REP_LIMIT_DEFAULT;
  localparam int PRE_SEED     = 5;
  localparam int STREAM       = 40;
  localparam int RESEED       = 10;
  localparam int HOLD_GAP     = 10;
  localparam int ZERO_IDLE    = 8;
  localparam int ALARM_RUN    = 8;
  localparam int ALARM_WAIT   = 5;
  localparam int RECOVER      = 10;
  // Nine single-cycle commands plus two tail cycles
  localparam int TEST_CYCLES  = RESET_CYCLES + PRE_SEED + STREAM + RESEED + 2 * HOLD_GAP +
                                2 * ZERO_IDLE + ALARM_RUN + ALARM_WAIT + RECOVER + 11;

  logic                 clk;
  logic                 reset_n;
  rng_cmd_e             cmd;
  logic [RNG_WIDTH-1:0] seed_a;
  logic [RNG_WIDTH-1:0] seed_b;
  logic [RNG_WIDTH-1:0] mask;
  logic                 mask_valid;
  logic                 alarm;

  // Reference model registers
  logic [RNG_WIDTH-1:0] m_a;
  logic [RNG_WIDTH-1:0] m_b;
  logic [RNG_WIDTH-1:0] m_cnt;
  comb_state_e          m_state;
  int                   m_rep;
  logic [RNG_WIDTH-1:0] exp_mask;
  logic                 exp_valid;
  logic                 exp_alarm;

  integer rand_seed    = 32'h98f891cb;
  int     mask_errors  = 0;
  int     valid_errors = 0;
  int     alarm_errors = 0;
  int     other_errors = 0;
  int     valid_words  = 0;
  logic   alarm_seen   = 1'b0;

  tb_clock_gen #(
    .CLK_PERIOD   (CLK_PERIOD),
    .RESET_CYCLES (RESET_CYCLES)
  ) clock_gen_i (
    .clk     (clk),
    .reset_n (reset_n)
  );

  hmac_mask_gen dut_i (
    .clk        (clk),
    .reset_n    (reset_n),
    .cmd        (cmd),
    .seed_a     (seed_a),
    .seed_b     (seed_b),
    .mask       (mask),
    .mask_valid (mask_valid),
    .alarm      (alarm)
  );

  // ----------------------------------------
  // Reference model
  // ----------------------------------------

  // One LFSR step, first matching rule wins
  function automatic logic [RNG_WIDTH-1:0] lfsr_model_next(
    input logic [RNG_WIDTH-1:0] cur,
    input logic [RNG_WIDTH-1:0] seed,
    input logic                 zero,
    input logic                 load,
    input logic [RNG_WIDTH-1:0] cnt
  );
    logic new_bit;
    new_bit = ~(cur[31] ^ cur[21] ^ cur[1] ^ cur[0]);
    if (zero)
      return cnt;
    else if (load)
      return seed;
    else if (cur == '1)
      return cnt;
    else
      return {cur[RNG_WIDTH-2:0], new_bit};
  endfunction

  assign exp_alarm = (m_state == ST_ALARM);

  always @(posedge clk or negedge reset_n)
  begin
    logic                 do_zero;
    logic                 do_load;
    logic [RNG_WIDTH-1:0] word;
    if (!reset_n)
    begin
      m_a       <= '0;
      m_b       <= '0;
      m_cnt     <= '0;
      m_state   <= ST_IDLE;
      m_rep     <= 0;
      exp_mask  <= '0;
      exp_valid <= 1'b0;
    end
    else
    begin
      do_zero = (cmd == CMD_ZEROIZE);
      // Alarm blocks reseeding
      do_load = (cmd == CMD_SEED) && (m_state != ST_ALARM);
      word    = m_a ^ m_b;
      m_a     <= lfsr_model_next(m_a, seed_a, do_zero, do_load, m_cnt);
      m_b     <= lfsr_model_next(m_b, seed_b, do_zero, do_load, m_cnt);
      // Counter skips the all-ones value
      m_cnt   <= (m_cnt + 32'd1 == '1) ? '0 : m_cnt + 32'd1;
      if (do_zero)
      begin
        m_state   <= ST_IDLE;
        m_rep     <= 0;
        exp_mask  <= '0;
        exp_valid <= 1'b0;
      end
      else if (m_state == ST_IDLE && cmd == CMD_SEED)
        m_state <= ST_RUN;
      else if (m_state == ST_RUN)
      begin
        if (m_rep == REP_LIMIT)
        begin
          m_state   <= ST_ALARM;
          exp_valid <= 1'b0;
        end
        else if (cmd == CMD_RUN_HOLD)
          exp_valid <= 1'b0;
        else
        begin
          // Mask lags the LFSR state by one edge
          exp_mask  <= word;
          exp_valid <= 1'b1;
          m_rep     <= (word == exp_mask) ? m_rep + 1 : 1;
        end
      end
    end
  end

  // ----------------------------------------
  // Checks on the falling edge
  // ----------------------------------------

  mask_check_a: assert property (@(negedge clk) disable iff (!reset_n) mask == exp_mask)
  else
  begin
    mask_errors++;
    $display("Error at %0t: mask expected %h, got %h", $time, exp_mask, mask);
  end

  valid_check_a: assert property (@(negedge clk) disable iff (!reset_n)
    mask_valid == exp_valid)
  else
  begin
    valid_errors++;
    $display("Error at %0t: mask_valid expected %b, got %b", $time, exp_valid, mask_valid);
  end

  alarm_check_a: assert property (@(negedge clk) disable iff (!reset_n) alarm == exp_alarm)
  else
  begin
    alarm_errors++;
    $display("Error at %0t: alarm expected %b, got %b", $time, exp_alarm, alarm);
  end

  // Reach tracking
  always @(negedge clk)
  begin
    if (alarm)
      alarm_seen <= 1'b1;
    if (mask_valid)
      valid_words <= valid_words + 1;
  end

  // ----------------------------------------
  // Stimulus
  // ----------------------------------------

  task automatic run_cmd(input rng_cmd_e c, input int cycles);
    repeat (cycles)
    begin
      @(posedge clk);
      cmd <= c;
    end
  endtask

  task automatic load_seeds(input logic [RNG_WIDTH-1:0] a, input logic [RNG_WIDTH-1:0] b);
    @(posedge clk);
    seed_a <= a;
    seed_b <= b;
    cmd    <= CMD_SEED;
  endtask

  // All-ones is the LFSR dead state, draw again
  task automatic draw_seed(output logic [RNG_WIDTH-1:0] value);
    do
      value = $random(rand_seed);
    while (value == '1);
  endtask

  initial
  begin
    logic [RNG_WIDTH-1:0] sa;
    logic [RNG_WIDTH-1:0] sb;
    cmd    = CMD_NOP;
    seed_a = '0;
    seed_b = '0;
    @(posedge reset_n);
    // Quiet until the first seed
    run_cmd(CMD_NOP, PRE_SEED);
    draw_seed(sa);
    draw_seed(sb);
    load_seeds(sa, sb);
    run_cmd(CMD_NOP, STREAM);
    // Reseed mid-stream
    draw_seed(sa);
    draw_seed(sb);
    load_seeds(sa, sb);
    run_cmd(CMD_NOP, RESEED);
    // Two single-cycle holds
    run_cmd(CMD_RUN_HOLD, 1);
    run_cmd(CMD_NOP, HOLD_GAP);
    run_cmd(CMD_RUN_HOLD, 1);
    run_cmd(CMD_NOP, HOLD_GAP);
    run_cmd(CMD_ZEROIZE, 1);
    run_cmd(CMD_NOP, ZERO_IDLE);
    // Equal seeds give a stuck zero mask
    draw_seed(sa);
    load_seeds(sa, sa);
    run_cmd(CMD_NOP, ALARM_RUN);
    // Seed while alarmed is ignored
    draw_seed(sa);
    draw_seed(sb);
    load_seeds(sa, sb);
    run_cmd(CMD_NOP, ALARM_WAIT);
    run_cmd(CMD_ZEROIZE, 1);
    run_cmd(CMD_NOP, ZERO_IDLE);
    // Recovery after the alarm
    draw_seed(sa);
    draw_seed(sb);
    load_seeds(sa, sb);
    run_cmd(CMD_NOP, RECOVER);
    repeat (2) @(posedge clk);

    if (!alarm_seen)
    begin
      other_errors++;
      $display("The health alarm never went high during the equal-seed phase");
    end
    if (valid_words < STREAM)
    begin
      other_errors++;
      $display("Only %0d valid mask words were seen, fewer than expected", valid_words);
    end
    $display("Error counts: mask %0d, mask_valid %0d, alarm %0d, other %0d",
             mask_errors, valid_errors, alarm_errors, other_errors);
    if (mask_errors + valid_errors + alarm_errors + other_errors == 0)
      $display("test passed");
    else
      $display("test failed");
    $finish;
  end

  // ----------------------------------------
  // Watchdog
  // ----------------------------------------

  initial
  begin
    #((TEST_CYCLES + 50) * CLK_PERIOD);
    $display("The run timed out after %0d cycles without finishing", TEST_CYCLES + 50);
    $display("test failed");
    $finish;
  end

endmodule

//--- tests/tb_clock_gen.sv
`timescale 1ns/1ns

module tb_clock_gen
#(
  parameter int CLK_PERIOD   = 20,
  parameter int RESET_CYCLES = 5
)
(
  output logic clk,
  output logic reset_n
);

  // Free-running clock
  initial
  begin
    clk = 1'b0;
    forever #(CLK_PERIOD / 2) clk = ~clk;
  end

  // Reset low for a fixed number of rising edges
  initial
  begin
    reset_n = 1'b0;
    repeat (RESET_CYCLES) @(posedge clk);
    reset_n <= 1'b1;
  end

endmodule

//--- hdl/hmac_mask_gen.sv
`timescale 1ns/1ns

module hmac_mask_gen
#(
  // Health test limit, handed to the combiner
  parameter int REP_LIMIT = hmac_rng_param_pkg::REP_LIMIT_DEFAULT
)
(
  input  logic                                     clk,
  input  logic                                     reset_n,
  input  hmac_rng_ctrl_pkg::rng_cmd_e              cmd,
  input  logic [hmac_rng_param_pkg::RNG_WIDTH-1:0] seed_a,
  input  logic [hmac_rng_param_pkg::RNG_WIDTH-1:0] seed_b,
  output logic [hmac_rng_param_pkg::RNG_WIDTH-1:0] mask,
  output logic                                     mask_valid,
  output logic                                     alarm
);

  import hmac_rng_param_pkg::*;

  // ----------------------------------------
  // Internal wiring
  // ----------------------------------------

  // Raw words from each LFSR
  logic [RNG_WIDTH-1:0] rnd_a;
  logic [RNG_WIDTH-1:0] rnd_b;

  // Shared strobes, both LFSRs act together
  logic                 lfsr_load;
  logic                 lfsr_zeroize;

  // ----------------------------------------
  // Randomness sources
  // ----------------------------------------

  hmac_lfsr lfsr_a_i (
    .clk     (clk),
    .reset_n (reset_n),
    .zeroize (lfsr_zeroize),
    .en      (lfsr_load),
    .seed    (seed_a),
    .rnd     (rnd_a)
  );

  hmac_lfsr lfsr_b_i (
    .clk     (clk),
    .reset_n (reset_n),
    .zeroize (lfsr_zeroize),
    .en      (lfsr_load),
    .seed    (seed_b),
    .rnd     (rnd_b)
  );

  // ----------------------------------------
  // Mask combiner and health test
  // ----------------------------------------

  hmac_mask_combiner #(
    .REP_LIMIT (REP_LIMIT)
  ) combiner_i (
    .clk          (clk),
    .reset_n      (reset_n),
    .cmd          (cmd),
    .rnd_a        (rnd_a),
    .rnd_b        (rnd_b),
    .lfsr_load    (lfsr_load),
    .lfsr_zeroize (lfsr_zeroize),
    .mask         (mask),
    .mask_valid   (mask_valid),
    .alarm        (alarm)
  );

endmodule

//--- hdl/hmac_mask_combiner.sv
`timescale 1ns/1ns

module hmac_mask_combiner
#(
  // Equal words in a row before the alarm, at most 15
  parameter int REP_LIMIT = hmac_rng_param_pkg::REP_LIMIT_DEFAULT
)
(
  input  logic                                     clk,
  input  logic                                     reset_n,
  input  hmac_rng_ctrl_pkg::rng_cmd_e              cmd,
  input  logic [hmac_rng_param_pkg::RNG_WIDTH-1:0] rnd_a,
  input  logic [hmac_rng_param_pkg::RNG_WIDTH-1:0] rnd_b,
  output logic                                     lfsr_load,
  output logic                                     lfsr_zeroize,
  output logic [hmac_rng_param_pkg::RNG_WIDTH-1:0] mask,
  output logic                                     mask_valid,
  output logic                                     alarm
);

  import hmac_rng_param_pkg::*;
  import hmac_rng_ctrl_pkg::*;

  // ----------------------------------------
  // Declarations
  // ----------------------------------------

  comb_state_e              state_q;
  logic [RNG_WIDTH-1:0]     mask_q;
  logic                     valid_q;
  logic [RNG_WIDTH-1:0]     rnd_xor;
  logic [REP_CNT_WIDTH-1:0] rep_cnt_q;
  logic [REP_CNT_WIDTH-1:0] rep_cnt_next;
  logic                     word_repeat;
  logic                     rep_limit_hit;

  // ----------------------------------------
  // Command decode
  // ----------------------------------------

  // Strobes act on the same edge that samples cmd
  always_comb
  begin
    // Alarmed FSM must not reseed the LFSRs
    lfsr_load    = (cmd == CMD_SEED) && (state_q != ST_ALARM);
    lfsr_zeroize = (cmd == CMD_ZEROIZE);
  end

  // ----------------------------------------
  // Mask word and health test
  // ----------------------------------------

  // Two independent streams folded into one
  assign rnd_xor = rnd_a ^ rnd_b;

  // Zero count means no previous word in this run
  assign word_repeat = (rnd_xor == mask_q) && (rep_cnt_q != '0);

  // Restart at 1 on a fresh word
  assign rep_cnt_next = word_repeat ? rep_cnt_q + 1'b1 : REP_CNT_WIDTH'(1);

  // REP_LIMIT equal words already out, next edge trips
  assign rep_limit_hit = (rep_cnt_q == REP_CNT_WIDTH'(REP_LIMIT));

  // ----------------------------------------
  // Combiner FSM
  // ----------------------------------------

  always_ff @(posedge clk or negedge reset_n)
  begin
    if (!reset_n)
    begin
      state_q   <= ST_IDLE;
      mask_q    <= '0;
      valid_q   <= 1'b0;
      rep_cnt_q <= '0;
    end
    else if (cmd == CMD_ZEROIZE)
    begin
      // Wipe from any state, clears the alarm too
      state_q   <= ST_IDLE;
      mask_q    <= '0;
      valid_q   <= 1'b0;
      rep_cnt_q <= '0;
    end
    else
    begin
      case (state_q)
        ST_IDLE:
        begin
          // LFSRs take seeds now, first word next edge
          if (cmd == CMD_SEED)
            state_q <= ST_RUN;
        end
        ST_RUN:
        begin
          if (rep_limit_hit)
          begin
            // Stuck output, stop the stream
            state_q <= ST_ALARM;
            valid_q <= 1'b0;
          end
          else if (cmd == CMD_RUN_HOLD)
          begin
            // Keep the word, counter frozen
            valid_q <= 1'b0;
          end
          else
          begin
            // NOP or reseed, one word per edge
            mask_q    <= rnd_xor;
            valid_q   <= 1'b1;
            rep_cnt_q <= rep_cnt_next;
          end
        end
        ST_ALARM:
        begin
          // Sticky until zeroize
          state_q <= ST_ALARM;
        end
        default:
        begin
          state_q <= ST_IDLE;
        end
      endcase
    end
  end

  // ----------------------------------------
  // Outputs
  // ----------------------------------------

  assign mask       = mask_q;
  assign mask_valid = valid_q;
  assign alarm      = (state_q == ST_ALARM);

  // ----------------------------------------
  // Assertions
  // ----------------------------------------

  // Both LFSRs see one action per edge
  strobe_excl_a: assert property (
    @(posedge clk) disable iff (!reset_n)
    !(lfsr_load && lfsr_zeroize)
  );

  // Valid words only come out of the running state
  valid_in_run_a: assert property (
    @(posedge clk) disable iff (!reset_n)
    mask_valid |-> (state_q == ST_RUN)
  );

  // No mask reaches the consumer while alarmed
  alarm_blocks_valid_a: assert property (
    @(posedge clk) disable iff (!reset_n)
    alarm |-> !mask_valid
  );

endmodule

//--- hdl/hmac_lfsr.sv
`timescale 1ns/1ns

module hmac_lfsr
(
  input  logic                                     clk,
  input  logic                                     reset_n,
  input  logic                                     zeroize,
  // Seed load strobe
  input  logic                                     en,
  input  logic [hmac_rng_param_pkg::RNG_WIDTH-1:0] seed,
  output logic [hmac_rng_param_pkg::RNG_WIDTH-1:0] rnd
);

  import hmac_rng_param_pkg::*;

  // ----------------------------------------
  // State and counter registers
  // ----------------------------------------

  logic [RNG_WIDTH-1:0] state_q;
  logic [RNG_WIDTH-1:0] state_next;
  logic [RNG_WIDTH-1:0] cnt_q;
  logic [RNG_WIDTH-1:0] cnt_next;
  logic                 feedback;
  logic                 lockup;

  // Taps 32, 22, 2, 1 as bit indices 31, 21, 1, 0
  assign feedback = state_q[31] ^ state_q[21] ^ state_q[1] ^ state_q[0];

  // XNOR form, so all-ones is the dead state
  assign state_next = {state_q[RNG_WIDTH-2:0], ~feedback};

  // Dead state detect
  assign lockup = &state_q;

  // ----------------------------------------
  // LFSR update, first match wins
  // ----------------------------------------

  always_ff @(posedge clk or negedge reset_n)
  begin
    if (!reset_n)
      state_q <= '0;
    else if (zeroize)
      // Overwrite with a value unrelated to the seed
      state_q <= cnt_q;
    else if (en)
      state_q <= seed;
    else if (lockup)
      // Escape, counter never holds all-ones
      state_q <= cnt_q;
    else
      state_q <= state_next;
  end

  // ----------------------------------------
  // Free-running counter
  // ----------------------------------------

  assign cnt_next = cnt_q + 1'b1;

  // Wraps one step early so all-ones is never reached
  always_ff @(posedge clk or negedge reset_n)
  begin
    if (!reset_n)
      cnt_q <= '0;
    else if (&cnt_next)
      cnt_q <= '0;
    else
      cnt_q <= cnt_next;
  end

  assign rnd = state_q;

  // Lockup escape works within one cycle unless a load holds it there
  lockup_escape_a: assert property (
    @(posedge clk) disable iff (!reset_n)
    (lockup && !en) |=> !lockup
  );

endmodule

//--- hdl/hmac_rng_ctrl_pkg.sv
package hmac_rng_ctrl_pkg;

  // ----------------------------------------
  // Host command opcodes
  // ----------------------------------------

  // Sampled every edge, no handshake
  // RUN_HOLD pauses mask output for one cycle only
  typedef enum logic [1:0] {
    CMD_NOP      = 2'b00,
    CMD_SEED     = 2'b01,
    CMD_RUN_HOLD = 2'b10,
    CMD_ZEROIZE  = 2'b11
  } rng_cmd_e;

  // ----------------------------------------
  // Combiner FSM states
  // ----------------------------------------

  // ALARM is sticky, left only through zeroize
  typedef enum logic [1:0] {
    ST_IDLE  = 2'b00,
    ST_RUN   = 2'b01,
    ST_ALARM = 2'b10
  } comb_state_e;

endpackage

//--- hdl/hmac_rng_param_pkg.sv
package hmac_rng_param_pkg;

  // ----------------------------------------
  // Randomness path widths
  // ----------------------------------------

  // LFSR state, seed and mask width
  // Taps 32/22/2/1 are only maximal for 32 bits
  parameter int RNG_WIDTH = 32;

  // ----------------------------------------
  // Repetition-count health test
  // ----------------------------------------

  // Consecutive equal mask words before alarm
  parameter int REP_LIMIT_DEFAULT = 4;

  // Counter width, covers limits up to 15
  parameter int REP_CNT_WIDTH = 4;

endpackage
